/* list.f */
rtl/wb_pkg.sv
rtl/flash_pkg.sv
rtl/flash_addr_regs.sv
rtl/flash_read_seq.sv
rtl/flash8_bridge.sv
tests/flash_model.sv
tests/flash8_bridge_properties.sv
tests/flash8_bridge_tb.sv

/* tests/flash8_bridge_tb.sv */
// Testbench for the Wishbone to 8-bit flash bridge
// Directed tests for window writes, byte and word reads, with a
// behavioral flash on the pads and a cycle watchdog
`timescale 1ns/1ps
`default_nettype none

module flash8_bridge_tb;

  localparam int ACCESS_CYCLES = 3;
  localparam int RESET_CYCLES  = 16;
  localparam int ACK_WAIT      = 40;    // Clocks allowed per bus cycle

  logic                   wb_clk_i = 1'b0;
  logic                   wb_rst_i;
  logic [15:0]            wb_dat_i;
  logic [15:0]            wb_dat_o;
  logic                   wb_we_i;
  logic                   wb_adr_i;
  logic [1:0]             wb_sel_i;
  logic                   wb_stb_i;
  logic                   wb_cyc_i;
  logic                   wb_ack_o;
  flash_pkg::flash_pads_t flash_pads_o;
  wire logic [7:0]        flash_data_i; // From the flash model

  int                     errors     = 0;
  int                     checks     = 0;
  int                     bus_cycles = 0; // Bus cycles issued so far
  int                     cycle_cnt  = 0;
  integer                 seed       = 32'h18bb;
  flash_pkg::win_addr_t   exp_win    = '0; // Window as last written

  always #4 wb_clk_i = ~wb_clk_i;       // 8 ns period

  flash8_bridge #(.ACCESS_CYCLES(ACCESS_CYCLES)) dut (
    .wb_clk_i (wb_clk_i), .wb_rst_i (wb_rst_i),
    .wb_dat_i (wb_dat_i), .wb_dat_o (wb_dat_o),
    .wb_we_i  (wb_we_i),  .wb_adr_i (wb_adr_i),
    .wb_sel_i (wb_sel_i), .wb_stb_i (wb_stb_i),
    .wb_cyc_i (wb_cyc_i), .wb_ack_o (wb_ack_o),
    .flash_pads_o (flash_pads_o), .flash_data_i (flash_data_i)
  );

  flash_model #(.ACCESS_CYCLES(ACCESS_CYCLES)) u_flash (
    .wb_clk_i (wb_clk_i), .pads_i (flash_pads_o), .data_o (flash_data_i)
  );

  // --------------------------------------------------
  // Watchdog limit grows with each bus cycle
  // --------------------------------------------------
  always @(posedge wb_clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > ACK_WAIT * (bus_cycles + 1) + RESET_CYCLES) begin
      $display("Timeout at %0t: run stalled after %0d cycles", $time, cycle_cnt);
      $display("Checks: %0d, errors: %0d", checks, errors + 1);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // Expected flash byte is A[7:0] xor A[15:8]
  function automatic logic [7:0] flash_byte(input flash_pkg::flash_addr_t a);
    return a[7:0] ^ a[15:8];
  endfunction

  // --------------------------------------------------
  // Compare tasks
  // --------------------------------------------------
  task automatic check_data(input string name, input wb_pkg::wb_data_u got,
                            input wb_pkg::wb_data_u exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got.word, exp.word);
    end
  endtask

  task automatic check_addr(input string name, input flash_pkg::flash_addr_t got,
                            input flash_pkg::flash_addr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // --------------------------------------------------
  // Bus cycle tasks start just after a falling edge
  // --------------------------------------------------
  task automatic wb_write(input logic adr, input logic [15:0] dat, output logic touched);
    int waited;
    touched  = 1'b0;
    waited   = 0;
    bus_cycles++;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = 1'b1;
    wb_adr_i = adr;
    wb_sel_i = 2'b11;
    wb_dat_i = dat;
    do begin
      @(negedge wb_clk_i);
      waited++;
      if (!flash_pads_o.ce_n || !flash_pads_o.we_n) touched = 1'b1; // Flash must stay idle
    end while (!wb_ack_o && waited < ACK_WAIT);
    if (!wb_ack_o) begin
      errors++;
      $display("Error at %0t: write to register %0d was never acked", $time, adr);
    end
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    @(negedge wb_clk_i);                // One idle cycle
  endtask

  task automatic wb_read(input logic [1:0] sel, output wb_pkg::wb_data_u data,
                         output flash_pkg::flash_addr_t first_addr, output logic odd_seen);
    int waited;
    waited   = 0;
    odd_seen = 1'b0;
    bus_cycles++;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = 1'b0;
    wb_sel_i = sel;
    do begin
      @(negedge wb_clk_i);
      waited++;
      if (waited == 1) first_addr = flash_pads_o.addr; // Pads set at the first edge
      if (!flash_pads_o.ce_n && flash_pads_o.addr[0]) odd_seen = 1'b1;
    end while (!wb_ack_o && waited < ACK_WAIT);
    if (!wb_ack_o) begin
      errors++;
      $display("Error at %0t: read with sel %b was never acked", $time, sel);
    end
    data.word = wb_dat_o;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    @(negedge wb_clk_i);
  endtask

  // Loads both window registers and drops the data bits above the window
  task automatic load_window(input logic [15:0] alo, input logic [15:0] ahi);
    logic touched;
    wb_write(flash_pkg::REG_ALO, alo, touched);
    check_flag("flash touched by REG_ALO write", touched, 1'b0);
    wb_write(flash_pkg::REG_AHI, ahi, touched);
    check_flag("flash touched by REG_AHI write", touched, 1'b0);
    exp_win = {ahi[5:0], alo};
  endtask

  // --------------------------------------------------
  // Directed tests
  // --------------------------------------------------
  task automatic reset_state();
    check_flag("wb_ack_o", wb_ack_o, 1'b0);
    check_data("wb_dat_o", wb_dat_o, 16'h0000);
    check_flag("ce_n", flash_pads_o.ce_n, 1'b1);
  endtask

  task automatic window_write();
    wb_pkg::wb_data_u       data;
    flash_pkg::flash_addr_t first;
    logic                   odd;
    load_window(16'($random(seed)), 16'($random(seed)));
    wb_read(2'b01, data, first, odd);
    check_addr("pads.addr even", first, {exp_win, 1'b0});
    wb_read(2'b10, data, first, odd);
    check_addr("pads.addr odd", first, {exp_win, 1'b1});
  endtask

  task automatic byte_read(input logic [1:0] sel);
    wb_pkg::wb_data_u       data;
    wb_pkg::wb_data_u       exp;
    flash_pkg::flash_addr_t first;
    logic                   odd;
    exp.word = {8'h00, flash_byte({exp_win, sel[1]})}; // Always lane 0
    wb_read(sel, data, first, odd);
    check_data(sel[1] ? "wb_dat_o high lane" : "wb_dat_o low lane", data, exp);
  endtask

  task automatic word_read();
    wb_pkg::wb_data_u       data;
    wb_pkg::wb_data_u       exp;
    flash_pkg::flash_addr_t first;
    logic                   odd;
    exp.bytes.hi = flash_byte({exp_win, 1'b1});
    exp.bytes.lo = flash_byte({exp_win, 1'b0});
    wb_read(2'b11, data, first, odd);
    check_addr("pads.addr word start", first, {exp_win, 1'b0});
    check_flag("odd address presented", odd, 1'b1);
    check_data("wb_dat_o word", data, exp);
  endtask

  task automatic quiet_writes();
    logic touched;
    logic [15:0] ahi;
    wb_write(flash_pkg::REG_ALO, exp_win[15:0], touched); // Same window back
    check_flag("flash touched by write", touched, 1'b0);
    ahi = 16'($random(seed));           // Upper register only
    wb_write(flash_pkg::REG_AHI, ahi, touched);
    check_flag("flash touched by write", touched, 1'b0);
    exp_win[21:16] = ahi[5:0];
    check_flag("we_n", flash_pads_o.we_n, 1'b1);
    word_read();
  endtask

  initial begin
    wb_rst_i = 1'b1;
    wb_dat_i = '0;
    wb_we_i  = 1'b0;
    wb_adr_i = 1'b0;
    wb_sel_i = '0;
    wb_stb_i = 1'b0;
    wb_cyc_i = 1'b0;
    repeat (RESET_CYCLES) @(negedge wb_clk_i);
    wb_rst_i = 1'b0;
    @(negedge wb_clk_i);
    reset_state();
    window_write();
    byte_read(2'b01);
    byte_read(2'b10);
    repeat (4) begin
      load_window(16'($random(seed)), 16'($random(seed)));
      word_read();
    end
    quiet_writes();
    errors += dut.u_props.failures;     // Assertion failures count as errors
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tests/flash8_bridge_properties.sv */
// Bus and pad checks for the flash bridge
// Single-cycle ack, ack only for a live request, strobes that
// stay inactive and chip enable tied to output enable
`timescale 1ns/1ps
`default_nettype none

module flash8_bridge_properties (
  input wire logic                   wb_clk_i,
  input wire logic                   wb_rst_i,
  input wire logic                   stb_i,
  input wire logic                   cyc_i,
  input wire logic                   ack_i,
  input wire flash_pkg::flash_pads_t pads_i
);

  int failures = 0;                     // Assertion failures so far

  // --------------------------------------------------
  // Ack
  // --------------------------------------------------
  a_ack_one_cycle: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    ack_i |=> !ack_i)
    else begin
      $error("ack high for two cycles");
      failures++;
    end

  a_ack_needs_stb: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    ack_i |-> $past(stb_i && cyc_i))    // Ack registered off the request
    else begin
      $error("ack without stb");
      failures++;
    end

  // --------------------------------------------------
  // Pads
  // --------------------------------------------------
  a_strobes_idle: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    pads_i.we_n && pads_i.rst_n)
    else begin
      $error("we_n or rst_n driven low");
      failures++;
    end

  a_ce_is_oe: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    pads_i.ce_n == pads_i.oe_n)
    else begin
      $error("ce_n differs from oe_n");
      failures++;
    end

endmodule

bind flash8_bridge flash8_bridge_properties u_props (
  .wb_clk_i (wb_clk_i),
  .wb_rst_i (wb_rst_i),
  .stb_i    (wb_stb_i),
  .cyc_i    (wb_cyc_i),
  .ack_i    (wb_ack_o),
  .pads_i   (flash_pads_o)
);

`default_nettype wire

/* tests/flash_model.sv */
// Behavioral 8-bit NOR flash
// Returns address-derived data once the access time has passed
// since the chip was enabled or the address last changed
`timescale 1ns/1ps
`default_nettype none

module flash_model #(
  parameter int ACCESS_CYCLES = 3       // Access time in clocks
) (
  input  wire logic                   wb_clk_i,
  input  wire flash_pkg::flash_pads_t pads_i,   // Pads from the bridge
  output wire logic [7:0]             data_o    // Data toward the bridge
);

  flash_pkg::flash_addr_t last_addr = '0; // Address of the access in flight
  int                     ready_cnt = 0;  // Edges since access start
  logic                   enabled;

  assign enabled = !pads_i.ce_n && !pads_i.oe_n;

  // Data rule, low byte of A xor A shifted right by 8
  function automatic logic [7:0] byte_at(input flash_pkg::flash_addr_t a);
    return a[7:0] ^ 8'(a >> 8);
  endfunction

  // Access timer, restarted by enable or a new address
  always @(posedge wb_clk_i) begin
    if (!enabled) begin
      ready_cnt <= 0;
    end else if (pads_i.addr != last_addr || ready_cnt == 0) begin
      last_addr <= pads_i.addr;
      ready_cnt <= 1;
    end else if (ready_cnt < ACCESS_CYCLES) begin
      ready_cnt <= ready_cnt + 1;
    end
  end

  // Undriven until the byte is valid
  assign data_o = (enabled && ready_cnt >= ACCESS_CYCLES && pads_i.addr == last_addr) ?
                  byte_at(last_addr) : 8'hxx;

endmodule

`default_nettype wire

/* rtl/flash8_bridge.sv */
// Wishbone to 8-bit NOR flash bridge, top level
// Packs the flat bus ports into one request, hands it to the window
// registers and the read sequencer, and merges their acks.
// Reads only, the flash is never programmed.
`timescale 1ns/1ps
`default_nettype none

module flash8_bridge #(
  parameter int ACCESS_CYCLES = 3       // Flash access time in clocks
) (
  // Wishbone slave
  input  wire logic                 wb_clk_i,
  input  wire logic                 wb_rst_i,
  input  wire logic [15:0]          wb_dat_i,
  output logic [15:0]               wb_dat_o,
  input  wire logic                 wb_we_i,
  input  wire logic                 wb_adr_i,
  input  wire logic [1:0]           wb_sel_i,
  input  wire logic                 wb_stb_i,
  input  wire logic                 wb_cyc_i,
  output logic                      wb_ack_o,

  // Flash pads
  output flash_pkg::flash_pads_t    flash_pads_o,
  input  wire logic [7:0]           flash_data_i
);

  wb_pkg::wb_req_t      req;            // Bus request bundle
  flash_pkg::win_addr_t win_addr;       // Window from the registers
  wb_pkg::wb_data_u     rd_data;
  logic                 wr_ack;
  logic                 rd_ack;

  assign req = '{cyc: wb_cyc_i, stb: wb_stb_i, we: wb_we_i,
                 adr: wb_adr_i, sel: wb_sel_i, dat: wb_dat_i};

  // --------------------------------------------------
  // Blocks
  // --------------------------------------------------
  flash_addr_regs u_addr_regs (
    .wb_clk_i   (wb_clk_i),
    .wb_rst_i   (wb_rst_i),
    .req_i      (req),
    .win_addr_o (win_addr),
    .wr_ack_o   (wr_ack)
  );

  flash_read_seq #(
    .ACCESS_CYCLES (ACCESS_CYCLES)
  ) u_read_seq (
    .wb_clk_i     (wb_clk_i),
    .wb_rst_i     (wb_rst_i),
    .req_i        (req),
    .win_addr_i   (win_addr),
    .flash_data_i (flash_data_i),
    .pads_o       (flash_pads_o),
    .rd_data_o    (rd_data),
    .rd_ack_o     (rd_ack)
  );

  // Writes and reads never ack in the same cycle
  assign wb_ack_o = wr_ack | rd_ack;
  assign wb_dat_o = rd_data.word;       // Held until the next read

endmodule

`default_nettype wire

/* rtl/flash_read_seq.sv */
// Flash read sequencer
// Drives the flash pads for a bus read, waits out the access time,
// captures one or two bytes and returns them with a one-cycle ack.
// A word read fetches the even byte, then the odd byte, and packs
// them as hi odd, lo even.
`timescale 1ns/1ps
`default_nettype none

module flash_read_seq #(
  parameter int ACCESS_CYCLES = 3       // Flash access time in clocks
) (
  input  wire logic                 wb_clk_i,
  input  wire logic                 wb_rst_i,
  input  wire wb_pkg::wb_req_t      req_i,        // Bus request
  input  wire flash_pkg::win_addr_t win_addr_i,   // Window address
  input  wire logic [7:0]           flash_data_i, // Flash data bus
  output flash_pkg::flash_pads_t    pads_o,       // Flash pads
  output wb_pkg::wb_data_u          rd_data_o,    // Read data
  output logic                      rd_ack_o      // Read acknowledge
);

  localparam int CNT_W = $clog2(ACCESS_CYCLES + 1); // Wait counter width

  // One-hot phase bit positions
  localparam int S_IDLE = 0;
  localparam int S_EVEN = 1;            // Even byte access
  localparam int S_ODD  = 2;            // Odd byte access
  localparam int S_DONE = 3;            // Ack cycle

  logic [3:0]             phase_q;
  logic [3:0]             phase_d;
  logic [CNT_W-1:0]       cnt_q;        // Edges left before sampling
  logic                   cnt_done;
  logic                   rd_req;       // Read cycle on the bus
  logic                   word;         // Both lanes selected
  logic                   addr0;        // Byte bit below the window
  logic [7:0]             lb_q;         // Even byte of a word read
  flash_pkg::flash_addr_t addr_q;
  logic                   ce_n_q;
  logic                   oe_n_q;

  assign rd_req   = req_i.cyc & req_i.stb & ~req_i.we;
  assign word     = (req_i.sel == 2'b11);
  assign cnt_done = (cnt_q == '0);

  // Odd byte for a high lane read, or second half of a word read
  // Taken from the next phase so the pads change with the phase
  assign addr0 = (req_i.sel == 2'b10) | (word & phase_d[S_ODD]);

  // --------------------------------------------------
  // Phase sequencing
  // --------------------------------------------------
  always_comb begin
    phase_d = phase_q;                  // Hold by default
    case (1'b1)
      phase_q[S_IDLE]: begin
        if (rd_req) begin
          phase_d = 4'(1 << S_EVEN);    // Every read starts here
        end
      end
      phase_q[S_EVEN]: begin
        if (!rd_req) begin
          phase_d = 4'(1 << S_IDLE);    // Master gave up
        end else if (cnt_done) begin
          phase_d = word ? 4'(1 << S_ODD) : 4'(1 << S_DONE);
        end
      end
      phase_q[S_ODD]: begin
        if (!rd_req) begin
          phase_d = 4'(1 << S_IDLE);
        end else if (cnt_done) begin
          phase_d = 4'(1 << S_DONE);
        end
      end
      phase_q[S_DONE]: begin
        phase_d = 4'(1 << S_IDLE);      // One ack cycle only
      end
      default: begin
        phase_d = 4'(1 << S_IDLE);      // Recover from a bad encoding
      end
    endcase
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      phase_q <= 4'(1 << S_IDLE);
      cnt_q   <= '0;
    end else begin
      phase_q <= phase_d;
      if (phase_d != phase_q) begin
        cnt_q <= CNT_W'(ACCESS_CYCLES); // Restart on each phase entry
      end else if (!cnt_done) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // Pads, registered
  // --------------------------------------------------
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      addr_q <= '0;
      ce_n_q <= 1'b1;                   // Device deselected
      oe_n_q <= 1'b1;
    end else begin
      addr_q <= {win_addr_i, addr0};
      ce_n_q <= ~rd_req;                // High again the edge after stb falls
      oe_n_q <= ~rd_req;
    end
  end

  // No programming, so strobe and reset stay inactive
  assign pads_o = '{addr: addr_q, ce_n: ce_n_q, oe_n: oe_n_q,
                    we_n: 1'b1, rst_n: 1'b1};

  // --------------------------------------------------
  // Byte capture and word assembly
  // --------------------------------------------------
  // Even byte kept while the odd byte is fetched
  always_ff @(posedge wb_clk_i) begin
    if (phase_q[S_EVEN] && cnt_done) begin
      lb_q <= flash_data_i;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      rd_data_o <= '0;
      rd_ack_o  <= 1'b0;
    end else begin
      rd_ack_o <= phase_d[S_DONE];      // Ack together with the data
      if (phase_d[S_DONE]) begin
        if (word) begin
          rd_data_o.bytes.hi <= flash_data_i; // Odd byte
          rd_data_o.bytes.lo <= lb_q;         // Even byte
        end else begin
          rd_data_o.bytes.hi <= 8'h00;        // Byte reads use lane 0
          rd_data_o.bytes.lo <= flash_data_i;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/flash_addr_regs.sv */
// Flash window address registers
// Two write-only registers, loaded by bus writes, form the 22-bit
// window that every read is based on. Each write is acked for
// exactly one cycle.
`timescale 1ns/1ps
`default_nettype none

module flash_addr_regs (
  input  wire logic              wb_clk_i,
  input  wire logic              wb_rst_i,
  input  wire wb_pkg::wb_req_t   req_i,       // Bus request
  output flash_pkg::win_addr_t   win_addr_o,  // Window address
  output logic                   wr_ack_o     // Write acknowledge
);

  logic wr_req;                         // Write cycle to be served

  // Write cycle not yet acked
  // The ack term keeps a held stb from loading and acking twice
  assign wr_req = req_i.cyc & req_i.stb & req_i.we & ~wr_ack_o;

  // --------------------------------------------------
  // One ack per write
  // --------------------------------------------------
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      wr_ack_o <= 1'b0;
    end else begin
      wr_ack_o <= wr_req;               // Same edge as the load
    end
  end

  // --------------------------------------------------
  // Window register pair
  // --------------------------------------------------
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      win_addr_o <= '0;                 // Window starts at 0
    end else if (wr_req) begin
      // Lanes are not checked and the register takes what it holds
      case (req_i.adr)
        flash_pkg::REG_ALO: begin
          win_addr_o[flash_pkg::ALO_W-1:0] <= req_i.dat.word;
        end
        flash_pkg::REG_AHI: begin
          // Only the low 6 data bits matter here
          win_addr_o[flash_pkg::WIN_AW-1:flash_pkg::ALO_W] <=
            req_i.dat.word[flash_pkg::AHI_W-1:0];
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* rtl/flash_pkg.sv */
// Flash side types for the 8-bit flash bridge
// Byte address widths, window register layout and the pad bundle
`default_nettype none

package flash_pkg;

  localparam int FLASH_AW = 23;         // Flash byte address width
  localparam int WIN_AW   = FLASH_AW - 1; // Window drops the byte bit
  localparam int ALO_W    = 16;         // Bits held in REG_ALO
  localparam int AHI_W    = WIN_AW - ALO_W; // Bits held in REG_AHI

  typedef logic [FLASH_AW-1:0] flash_addr_t;
  typedef logic [WIN_AW-1:0]   win_addr_t;

  // --------------------------------------------------
  // Register offsets on wb adr
  // --------------------------------------------------
  localparam logic REG_ALO = 1'b0;      // Low 16 window bits
  localparam logic REG_AHI = 1'b1;      // Upper 6 window bits

  // Pads toward the flash device, strobes active low
  typedef struct packed {
    flash_addr_t addr;                  // Byte address
    logic        ce_n;                  // Chip enable
    logic        oe_n;                  // Output enable
    logic        we_n;                  // Write strobe, held high
    logic        rst_n;                 // Device reset, held high
  } flash_pads_t;

endpackage

`default_nettype wire

/* rtl/wb_pkg.sv */
// Wishbone side types for the 8-bit flash bridge
// One bus request as seen by the slave, and the 16-bit data word
// with its two byte lanes
`default_nettype none

package wb_pkg;

  localparam int DW = 16;               // Bus data width
  localparam int BW = 8;                // Byte lane width

  // Byte lanes of one data word
  typedef struct packed {
    logic [BW-1:0] hi;                  // Lane 1, sel[1]
    logic [BW-1:0] lo;                  // Lane 0, sel[0]
  } wb_bytes_t;

  // Data word, whole or per lane
  typedef union packed {
    logic [DW-1:0] word;
    wb_bytes_t     bytes;
  } wb_data_u;

  // --------------------------------------------------
  // One classic cycle request, master to slave
  // --------------------------------------------------
  typedef struct packed {
    logic     cyc;
    logic     stb;
    logic     we;                       // 1 = register write
    logic     adr;                      // Register offset
    logic [1:0] sel;                    // Byte lane select
    wb_data_u dat;                      // Write data
  } wb_req_t;

endpackage

`default_nettype wire
